// ==== hw/snd_pkg.sv ====
// sound subsystem package with widths, address map, PSG constants and the sound bus request.
`default_nettype none

package snd_pkg;

    // the shared RAM holds 2K words of 16 bits, so it is 4 KB in total.
    localparam int RAM_AW = 11;

    // cen pulses per PSG step and the level added per attenuation step.
    localparam int PSG_DIV      = 16;
    localparam int PSG_DIV_W    = $clog2(PSG_DIV);
    localparam int PSG_AMP_STEP = 16;

    typedef logic [15:0]         cpu_addr_t;
    typedef logic [7:0]          byte_t;
    typedef logic [15:0]         word_t;
    typedef logic [RAM_AW-1:0]   ram_addr_t;
    typedef logic [1:0]          region_t;
    typedef logic signed [7:0]   dac_t;
    typedef logic signed [11:0]  psg_sample_t;
    typedef logic signed [15:0]  audio_t;

    // address bits 15 to 14 pick the region on the sound side.
    localparam region_t REGION_RAM   = 2'd0;
    localparam region_t REGION_PSG   = 2'd1;
    localparam region_t REGION_LATCH = 2'd2;
    localparam region_t REGION_INT   = 2'd3;

    typedef struct packed {
        logic      valid;
        logic      we;
        cpu_addr_t addr;
        byte_t     wdata;
    } snd_bus_req_t;

endpackage

`default_nettype wire

// ==== hw/snd_dual_ram.sv ====
// byte-wide true dual-port RAM with a registered read on each port.
`timescale 1ns/1ns
`default_nettype none

module snd_dual_ram
    import snd_pkg::*;
#(
    parameter int AW = 11
) (
    input  wire            clk,
    input  wire [AW-1:0]   addr0,
    input  wire [AW-1:0]   addr1,
    input  wire byte_t     data0,
    input  wire byte_t     data1,
    input  wire            we0,
    input  wire            we1,
    output byte_t          q0,
    output byte_t          q1
);

    byte_t mem [2**AW];

    // both ports read the old contents when they write in the same cycle.
    always_ff @(posedge clk) begin
        if (we0) begin
            mem[addr0] <= data0;
        end
        if (we1) begin
            mem[addr1] <= data1;
        end
        q0 <= mem[addr0];
        q1 <= mem[addr1];
    end

    // the main CPU and the sound side must never hit the same byte at once.
    assert property (@(posedge clk) !(we0 && we1 && addr0 == addr1))
        else $error("dual ram: both ports write address %0h", addr0);

endmodule

`default_nettype wire

// ==== hw/snd_bus_decode.sv ====
// sound-side address decoder with chip selects, read-data mux, main latch and interrupt pulse.
`timescale 1ns/1ns
`default_nettype none

module snd_bus_decode
    import snd_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire snd_bus_req_t snd_req,
    input  wire byte_t        snd_latch,
    input  wire byte_t        ram_lsb,
    input  wire byte_t        ram_msb,
    output byte_t             snd_rdata,
    output ram_addr_t         ram_addr,
    output byte_t             ram_wdata,
    output logic [1:0]        ram_we,
    output logic              psg_we,
    output byte_t             psg_data,
    output byte_t             main_latch,
    output logic              main_int5
);

    region_t req_region;
    logic    wr;
    logic    ram_wr;
    logic    int_wr;
    logic    latch_wr;

    // state of the read issued in the previous cycle.
    logic    rd_valid;
    region_t rd_region;
    logic    rd_lane;
    byte_t   rd_latch;

    assign req_region = snd_req.addr[15:14];
    assign wr         = snd_req.valid && snd_req.we;
    assign ram_wr     = wr && req_region == REGION_RAM;
    assign int_wr     = wr && req_region == REGION_INT;
    assign latch_wr   = wr && req_region == REGION_LATCH;

    // bit 0 picks the byte lane, bits 11 to 1 the word.
    assign ram_addr  = snd_req.addr[11:1];
    assign ram_wdata = snd_req.wdata;
    assign ram_we    = {2{ram_wr}} & {snd_req.addr[0], ~snd_req.addr[0]};

    assign psg_we   = wr && req_region == REGION_PSG;
    assign psg_data = snd_req.wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid   <= 1'b0;
            main_latch <= '0;
            main_int5  <= 1'b0;
        end else begin
            rd_valid  <= snd_req.valid && !snd_req.we;
            main_int5 <= int_wr;
            if (latch_wr) begin
                main_latch <= snd_req.wdata;
            end
        end
    end

    // the latch is sampled with the request so the reply matches the request cycle.
    always_ff @(posedge clk) begin
        rd_region <= req_region;
        rd_lane   <= snd_req.addr[0];
        rd_latch  <= snd_latch;
    end

    // the RAM output is registered, so the reply is picked one cycle after the request.
    always_comb begin
        snd_rdata = '0;
        if (rd_valid) begin
            case (rd_region)
                REGION_RAM:   snd_rdata = rd_lane ? ram_msb : ram_lsb;
                REGION_LATCH: snd_rdata = rd_latch;
                default:      snd_rdata = '0;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0({ram_wr, psg_we, int_wr}))
        else $error("bus decode: more than one write strobe active");

endmodule

`default_nettype wire

// ==== hw/snd_psg.sv ====
// programmable sound generator with three square-wave tones and one LFSR noise channel.
`timescale 1ns/1ns
`default_nettype none

module snd_psg
    import snd_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         cen,
    input  wire         we,
    input  wire byte_t  data,
    output psg_sample_t psg_out,
    output logic        sample_tick
);

    logic [9:0] tone_period [3];
    logic [3:0] tone_att [3];
    logic [2:0] noise_ctrl;
    logic [3:0] noise_att;
    logic [1:0] tone_idx;
    logic       noise_wr;

    logic [PSG_DIV_W-1:0] div_cnt;
    logic                 step;

    logic [9:0]  tone_cnt [3];
    logic [2:0]  tone_exp;
    logic [2:0]  tone_pol;

    logic [14:0] lfsr;
    logic [1:0]  noise_pre;
    logic        noise_shift;
    logic        noise_fb;

    assign noise_wr = we && data[7] && data[6:4] == 3'd6;

    // register writes. A latch byte carries the index, a data byte the period's upper bits.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                tone_period[i] <= '0;
                tone_att[i]    <= 4'hf;
            end
            noise_ctrl <= '0;
            noise_att  <= 4'hf;
            tone_idx   <= '0;
        end else if (we) begin
            if (data[7]) begin
                case (data[6:4])
                    3'd0, 3'd2, 3'd4: begin
                        tone_period[data[6:5]][3:0] <= data[3:0];
                        tone_idx <= data[6:5];
                    end
                    3'd1, 3'd3, 3'd5: tone_att[data[6:5]] <= data[3:0];
                    3'd6:             noise_ctrl <= data[2:0];
                    default:          noise_att <= data[3:0];
                endcase
            end else begin
                tone_period[tone_idx][9:4] <= data[5:0];
            end
        end
    end

    // one step every PSG_DIV clock enables.
    assign step = cen && div_cnt == PSG_DIV_W'(PSG_DIV - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt     <= '0;
            sample_tick <= 1'b0;
        end else begin
            sample_tick <= step;
            if (step) begin
                div_cnt <= '0;
            end else if (cen) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            tone_exp[i] = tone_cnt[i] <= 10'd1;
        end
    end

    // a zero period reloads as one, so the channel then flips on every step.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                tone_cnt[i] <= '0;
            end
            tone_pol <= '0;
        end else if (step) begin
            for (int i = 0; i < 3; i++) begin
                if (tone_exp[i]) begin
                    tone_cnt[i] <= (tone_period[i] == '0) ? 10'd1 : tone_period[i];
                    tone_pol[i] <= ~tone_pol[i];
                end else begin
                    tone_cnt[i] <= tone_cnt[i] - 1'b1;
                end
            end
        end
    end

    // noise rate from control bits 1 to 0. Rate 3 follows the rising edge of tone 2.
    always_comb begin
        case (noise_ctrl[1:0])
            2'd0:    noise_shift = step;
            2'd1:    noise_shift = step && noise_pre[0];
            2'd2:    noise_shift = step && (&noise_pre);
            default: noise_shift = step && tone_exp[2] && !tone_pol[2];
        endcase
    end

    // control bit 2 selects white noise, otherwise the LFSR just rotates a single bit.
    assign noise_fb = noise_ctrl[2] ? lfsr[0] ^ lfsr[1] : lfsr[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            noise_pre <= '0;
        end else if (step) begin
            noise_pre <= noise_pre + 1'b1;
        end
        if (rst || noise_wr) begin
            lfsr <= 15'h4000;
        end else if (noise_shift) begin
            lfsr <= {noise_fb, lfsr[14:1]};
        end
    end

    function automatic psg_sample_t chan_level(input logic pol, input logic [3:0] att);
        psg_sample_t mag;
        mag = psg_sample_t'({8'd0, 4'd15 - att}) * psg_sample_t'(PSG_AMP_STEP);
        return pol ? mag : -mag;
    endfunction

    assign psg_out = chan_level(tone_pol[0], tone_att[0])
                   + chan_level(tone_pol[1], tone_att[1])
                   + chan_level(tone_pol[2], tone_att[2])
                   + chan_level(lfsr[0], noise_att);

    // data bytes always land on one of the three tone periods.
    assert property (@(posedge clk) disable iff (rst) tone_idx < 2'd3)
        else $error("psg: latched tone index %0d out of range", tone_idx);

endmodule

`default_nettype wire

// ==== hw/snd_mixer.sv ====
// stereo mixer that adds the scaled DAC and PSG inputs into registered 16-bit outputs.
`timescale 1ns/1ns
`default_nettype none

module snd_mixer
    import snd_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire dac_t        dac_l,
    input  wire dac_t        dac_r,
    input  wire psg_sample_t psg_in,
    input  wire              sample_tick,
    output audio_t           snd_l,
    output audio_t           snd_r,
    output logic             sample
);

    audio_t psg_term;

    // dac times 128 reaches 15 bits and psg times 8 stays under that, so the sum fits.
    assign psg_term = {psg_in[11], psg_in, 3'd0};

    always_ff @(posedge clk) begin
        snd_l <= audio_t'({dac_l[7], dac_l, 7'd0}) + psg_term;
        snd_r <= audio_t'({dac_r[7], dac_r, 7'd0}) + psg_term;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sample <= 1'b0;
        end else begin
            sample <= sample_tick;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ngp_snd.sv ====
// sound subsystem top with the shared RAM lanes, the bus decoder, the PSG and the mixer.
`timescale 1ns/1ns
`default_nettype none

module ngp_snd
    import snd_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               cen,
    input  wire ram_addr_t    main_addr,
    input  wire word_t        main_dout,
    input  wire [1:0]         main_we,
    input  wire snd_bus_req_t snd_req,
    input  wire byte_t        snd_latch,
    input  wire dac_t         snd_dacl,
    input  wire dac_t         snd_dacr,
    output word_t             main_din,
    output byte_t             snd_rdata,
    output byte_t             main_latch,
    output logic              main_int5,
    output logic              sample,
    output audio_t            snd_l,
    output audio_t            snd_r
);

    ram_addr_t   ram_addr;
    byte_t       ram_wdata;
    logic [1:0]  ram_we;
    byte_t       ram_lsb;
    byte_t       ram_msb;
    logic        psg_we;
    byte_t       psg_data;
    psg_sample_t psg_out;
    logic        sample_tick;

    // low byte lane. Port 0 is the main CPU and port 1 the sound side.
    snd_dual_ram #(.AW(RAM_AW)) u_ram_lo (
        .clk   (clk),
        .addr0 (main_addr),
        .addr1 (ram_addr),
        .data0 (main_dout[7:0]),
        .data1 (ram_wdata),
        .we0   (main_we[0]),
        .we1   (ram_we[0]),
        .q0    (main_din[7:0]),
        .q1    (ram_lsb)
    );

    snd_dual_ram #(.AW(RAM_AW)) u_ram_hi (
        .clk   (clk),
        .addr0 (main_addr),
        .addr1 (ram_addr),
        .data0 (main_dout[15:8]),
        .data1 (ram_wdata),
        .we0   (main_we[1]),
        .we1   (ram_we[1]),
        .q0    (main_din[15:8]),
        .q1    (ram_msb)
    );

    snd_bus_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .snd_req    (snd_req),
        .snd_latch  (snd_latch),
        .ram_lsb    (ram_lsb),
        .ram_msb    (ram_msb),
        .snd_rdata  (snd_rdata),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_we     (ram_we),
        .psg_we     (psg_we),
        .psg_data   (psg_data),
        .main_latch (main_latch),
        .main_int5  (main_int5)
    );

    snd_psg u_psg (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .we          (psg_we),
        .data        (psg_data),
        .psg_out     (psg_out),
        .sample_tick (sample_tick)
    );

    snd_mixer u_mixer (
        .clk         (clk),
        .rst         (rst),
        .dac_l       (snd_dacl),
        .dac_r       (snd_dacr),
        .psg_in      (psg_out),
        .sample_tick (sample_tick),
        .snd_l       (snd_l),
        .snd_r       (snd_r),
        .sample      (sample)
    );

endmodule

`default_nettype wire

// ==== test/ngp_snd_tb.sv ====
// testbench for the sound subsystem that checks shared RAM, latch, interrupt, PSG and mixer.
`timescale 1ns/1ns
`default_nettype none

module ngp_snd_tb
    import snd_pkg::*;
();

    localparam int N_WORDS = 64;
    localparam int N_LATCH = 8;
    localparam int N_INT   = 4;
    localparam int N_MIX   = 64;
    localparam int TONE_P  = 4;
    // one full tone period in clocks, with cen high on every other cycle.
    localparam int TONE_CYC = 2 * TONE_P * PSG_DIV * 2;
    localparam int TEST_CYC = 6 * N_WORDS + 3 * N_LATCH + 5 * N_INT + N_MIX + 2 * TONE_CYC + 22;
    localparam int TIMEOUT_CYCLES = 3 + TEST_CYC + 100;

    logic         clk;
    logic         rst;
    logic         cen;
    ram_addr_t    main_addr;
    word_t        main_dout;
    logic [1:0]   main_we;
    snd_bus_req_t snd_req;
    byte_t        snd_latch;
    dac_t         snd_dacl;
    dac_t         snd_dacr;
    word_t        main_din;
    byte_t        snd_rdata;
    byte_t        main_latch;
    logic         main_int5;
    logic         sample;
    audio_t       snd_l;
    audio_t       snd_r;

    // model of the shared memory, indexed by sound-side byte address.
    byte_t       ref_mem [4096];
    byte_t       ref_latch;
    ram_addr_t   waddr [N_WORDS];
    logic [11:0] baddr [N_WORDS];

    // expectations set with the request, then delayed one cycle to meet the response.
    logic   rd_due;
    logic   main_due;
    logic   int_due;
    logic   mix_due;
    byte_t  rd_exp;
    word_t  main_exp;
    audio_t mixl_exp;
    audio_t mixr_exp;
    logic   rd_chk;
    logic   main_chk;
    logic   int_chk;
    logic   mix_chk;
    byte_t  rd_val;
    byte_t  latch_val;
    word_t  main_val;
    audio_t mixl_val;
    audio_t mixr_val;

    logic checking;
    int   checks;
    int   errors;
    int   cycles = 0;
    int   seed;

    ngp_snd dut0 (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .main_addr  (main_addr),
        .main_dout  (main_dout),
        .main_we    (main_we),
        .snd_req    (snd_req),
        .snd_latch  (snd_latch),
        .snd_dacl   (snd_dacl),
        .snd_dacr   (snd_dacr),
        .main_din   (main_din),
        .snd_rdata  (snd_rdata),
        .main_latch (main_latch),
        .main_int5  (main_int5),
        .sample     (sample),
        .snd_l      (snd_l),
        .snd_r      (snd_r)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // the PSG and INT regions read as zero, the LATCH region returns the latch input.
    function automatic byte_t sound_read_model(input cpu_addr_t addr, input byte_t latch);
        case (addr[15:14])
            REGION_RAM:   return ref_mem[addr[11:0]];
            REGION_LATCH: return latch;
            default:      return 8'h00;
        endcase
    endfunction

    function automatic word_t main_word_model(input ram_addr_t addr);
        return {ref_mem[{addr, 1'b1}], ref_mem[{addr, 1'b0}]};
    endfunction

    function automatic audio_t mixer_model(input dac_t dac, input int psg);
        return audio_t'(int'(dac) * 128 + psg * 8);
    endfunction

    task automatic byte_compare(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic word_compare(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic audio_compare(input string name, input audio_t got, input audio_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    task automatic bit_compare(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    always @(posedge clk) begin
        rd_chk    <= rd_due;
        rd_val    <= rd_exp;
        main_chk  <= main_due;
        main_val  <= main_exp;
        int_chk   <= int_due;
        latch_val <= ref_latch;
        mix_chk   <= mix_due;
        mixl_val  <= mixl_exp;
        mixr_val  <= mixr_exp;
    end

    // outputs are compared mid-cycle, well away from the edge that updates them.
    always @(negedge clk) begin
        if (checking) begin
            byte_compare("snd_rdata", snd_rdata, rd_chk ? rd_val : 8'h00);
            byte_compare("main_latch", main_latch, latch_val);
            bit_compare("main_int5", main_int5, int_chk);
            if (main_chk) begin
                word_compare("main_din", main_din, main_val);
            end
            if (mix_chk) begin
                audio_compare("snd_l", snd_l, mixl_val);
                audio_compare("snd_r", snd_r, mixr_val);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // the latch input changes every cycle so a read shows which cycle it sampled.
    task automatic next_cycle();
        @(posedge clk);
        #5;
        cen       = ~cen;
        snd_latch = byte_t'($urandom);
        snd_req   = '0;
        main_we   = 2'b00;
        rd_due    = 1'b0;
        main_due  = 1'b0;
        int_due   = 1'b0;
        mix_due   = 1'b0;
    endtask

    task automatic sound_access(input logic we, input cpu_addr_t addr, input byte_t wdata);
        next_cycle();
        snd_req.valid = 1'b1;
        snd_req.we    = we;
        snd_req.addr  = addr;
        snd_req.wdata = wdata;
        if (we) begin
            case (addr[15:14])
                REGION_RAM:   ref_mem[addr[11:0]] = wdata;
                REGION_LATCH: ref_latch = wdata;
                REGION_INT:   int_due = 1'b1;
                default:      ;
            endcase
        end else begin
            rd_due = 1'b1;
            rd_exp = sound_read_model(addr, snd_latch);
        end
    endtask

    task automatic main_access(input logic [1:0] we, input ram_addr_t addr, input word_t data);
        next_cycle();
        main_addr = addr;
        main_we   = we;
        main_dout = data;
        if (we[0]) begin
            ref_mem[{addr, 1'b0}] = data[7:0];
        end
        if (we[1]) begin
            ref_mem[{addr, 1'b1}] = data[15:8];
        end
        if (we == 2'b00) begin
            main_due = 1'b1;
            main_exp = main_word_model(addr);
        end
    endtask

    task automatic end_test(input int num, input string name, input int err_start);
        next_cycle();
        next_cycle();
        $display("test %0d %s: %0d errors", num, name, errors - err_start);
    endtask

    initial begin
        int         err0;
        int         pos;
        int         neg;
        int         pulses;
        int         diff_l;
        int         diff_r;
        logic [1:0] lanes;
        seed      = $urandom(79);
        rst       = 1'b1;
        cen       = 1'b0;
        main_addr = '0;
        main_dout = '0;
        main_we   = 2'b00;
        snd_req   = '0;
        snd_latch = '0;
        snd_dacl  = '0;
        snd_dacr  = '0;
        rd_due    = 1'b0;
        main_due  = 1'b0;
        int_due   = 1'b0;
        mix_due   = 1'b0;
        rd_exp    = '0;
        main_exp  = '0;
        mixl_exp  = '0;
        mixr_exp  = '0;
        ref_latch = '0;
        checking  = 1'b0;
        checks    = 0;
        errors    = 0;
        repeat (3) @(posedge clk);
        #5;
        rst      = 1'b0;
        checking = 1'b1;

        // full words first, so partial lane writes never leave an unknown byte behind.
        err0 = errors;
        for (int i = 0; i < N_WORDS; i++) begin
            waddr[i] = ram_addr_t'($urandom);
            main_access(2'b11, waddr[i], word_t'($urandom));
        end
        for (int i = 0; i < N_WORDS; i++) begin
            lanes = 2'($urandom % 3 + 1);
            main_access(lanes, waddr[i], word_t'($urandom));
        end
        for (int i = 0; i < N_WORDS; i++) begin
            sound_access(1'b0, {4'd0, waddr[i], 1'b0}, 8'h00);
            sound_access(1'b0, {4'd0, waddr[i], 1'b1}, 8'h00);
        end
        end_test(1, "main write, sound read", err0);

        err0 = errors;
        for (int i = 0; i < N_WORDS; i++) begin
            baddr[i] = {waddr[$urandom % N_WORDS], ($urandom % 2) == 1};
            sound_access(1'b1, {4'd0, baddr[i]}, byte_t'($urandom));
        end
        for (int i = 0; i < N_WORDS; i++) begin
            main_access(2'b00, baddr[i][11:1], '0);
        end
        end_test(2, "sound write, main read", err0);

        err0 = errors;
        for (int i = 0; i < N_LATCH; i++) begin
            sound_access(1'b0, 16'h8000 | cpu_addr_t'($urandom % 16384), 8'h00);
            sound_access(1'b1, 16'h8000 | cpu_addr_t'($urandom % 16384), byte_t'($urandom));
            next_cycle();
        end
        end_test(3, "latch read and write", err0);

        // reads of the INT and PSG regions must return zero without a pulse.
        err0 = errors;
        for (int i = 0; i < N_INT; i++) begin
            sound_access(1'b1, 16'hc000 | cpu_addr_t'($urandom % 16384), byte_t'($urandom));
            next_cycle();
            sound_access(1'b0, 16'hc000 | cpu_addr_t'($urandom % 16384), 8'h00);
            sound_access(1'b0, 16'h4000 | cpu_addr_t'($urandom % 16384), 8'h00);
            next_cycle();
        end
        end_test(4, "interrupt pulse", err0);

        err0 = errors;
        for (int i = 0; i < N_MIX; i++) begin
            next_cycle();
            snd_dacl = dac_t'($urandom);
            snd_dacr = dac_t'($urandom);
            mix_due  = 1'b1;
            mixl_exp = mixer_model(snd_dacl, 0);
            mixr_exp = mixer_model(snd_dacr, 0);
        end
        end_test(5, "silent PSG mixer", err0);

        // tone 0 period low and high parts, then attenuation 0 for full level.
        err0 = errors;
        sound_access(1'b1, 16'h4000, byte_t'(8'h80 | (TONE_P & 15)));
        sound_access(1'b1, 16'h4000, byte_t'(TONE_P >> 4));
        sound_access(1'b1, 16'h4000, 8'h90);
        next_cycle();
        snd_dacl = dac_t'($urandom);
        snd_dacr = dac_t'($urandom);
        next_cycle();
        next_cycle();
        pos    = 0;
        neg    = 0;
        pulses = 0;
        repeat (2 * TONE_CYC) begin
            next_cycle();
            diff_l = int'(snd_l) - int'(mixer_model(snd_dacl, 0));
            diff_r = int'(snd_r) - int'(mixer_model(snd_dacr, 0));
            audio_compare("snd_l psg term", audio_t'(diff_l < 0 ? -diff_l : diff_l),
                          audio_t'(15 * PSG_AMP_STEP * 8));
            audio_compare("snd_r psg term", audio_t'(diff_r < 0 ? -diff_r : diff_r),
                          audio_t'(15 * PSG_AMP_STEP * 8));
            if (diff_l > 0) begin
                pos++;
            end else if (diff_l < 0) begin
                neg++;
            end
            if (sample) begin
                pulses++;
            end
        end
        checks += 2;
        if (pos == 0 || neg == 0) begin
            errors++;
            $display("tone 0 did not take both signs within %0d cycles", 2 * TONE_CYC);
        end
        if (pulses != 2 * TONE_CYC / (2 * PSG_DIV)) begin
            errors++;
            $display("sample pulsed %0d times, expected %0d", pulses,
                     2 * TONE_CYC / (2 * PSG_DIV));
        end
        end_test(6, "PSG tone 0", err0);

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ngp_snd.f ====
hw/snd_pkg.sv
hw/snd_dual_ram.sv
hw/snd_bus_decode.sv
hw/snd_psg.sv
hw/snd_mixer.sv
hw/ngp_snd.sv
test/ngp_snd_tb.sv
